// File: bench/graphicsChecks.sv
// concurrent checks on the graphics top ports against a reference image
// check and error counters for the testbench report
`default_nettype none

`include "gfx_consts.svh"

module graphicsChecks (
    input  logic              clk,
    input  logic              rst,
    input  logic              hostRead,
    input  logic              hostWrite,
    input  gfxBusPkg::fbAddrT hostAddr,
    input  logic              hostBusy,
    input  gfxBusPkg::pixelT  hostReadData,
    input  logic              hostReadValid,
    input  logic              fillStart,
    input  logic              fillBusy,
    input  logic              fillDone,
    input  logic              scanEnable,
    input  gfxBusPkg::pixelT  pixelOut,
    input  logic              pixelValid,
    input  logic              frameStart
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ScreenWords = `GFX_SCREEN_W * `GFX_SCREEN_H;

    // reference image, written by the testbench
    gfxBusPkg::pixelT refMem [`GFX_FB_WORDS];

    int checkCount;
    int errorCount;
    // accepted fills not yet answered by fillDone
    int outstanding;
    // valid pixels since the last frame start
    int frameCount;
    logic seenFrame;
    logic readAccept;
    gfxBusPkg::pixelT expRead;
    // raster index of the pixel on pixelOut, counted from scan start
    int expIndex;
    gfxBusPkg::pixelT expPixel;

    assign readAccept = hostRead && !hostWrite && !hostBusy;
    assign expPixel = refMem[expIndex];

    // expected word taken from the model when the read strobe is latched
    always @(posedge clk) begin
        if (!rst && readAccept) begin
            if (hostAddr < gfxBusPkg::fbAddrT'(`GFX_FB_WORDS)) begin
                expRead <= refMem[hostAddr];
            end else begin
                // past the last bank reads zero
                expRead <= '0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(fillStart && !fillBusy) - int'(fillDone);
        end
        // scan restarts from address 0 after scanEnable drops
        if (rst || !scanEnable) begin
            seenFrame <= 1'b0;
            frameCount <= 0;
            expIndex <= 0;
        end else if (pixelValid) begin
            // wraps at the end of each frame
            expIndex <= (expIndex == ScreenWords - 1) ? 0 : expIndex + 1;
            if (frameStart) begin
                seenFrame <= 1'b1;
                frameCount <= 1;
            end else begin
                frameCount <= frameCount + 1;
            end
        end
        if (rst || hostReadValid || pixelValid || fillDone) begin
            checkCount <= checkCount + 1;
        end
    end

    afterReset: assert property (@(posedge clk)
        rst |=> !hostBusy && !hostReadValid && !fillBusy && !fillDone
                && !pixelValid && !frameStart)
    else begin
        $display("outputs not idle in the cycle after reset");
        errorCount++;
    end

    // strobe latched at n, valid pulse set at n+2
    readLatency: assert property (@(posedge clk) disable iff (rst)
        hostReadValid == $past(readAccept, 3))
    else begin
        $display("mismatch hostReadValid got %h expected %h",
                 $sampled(hostReadValid), $past(readAccept, 3));
        errorCount++;
    end

    readData: assert property (@(posedge clk) disable iff (rst)
        hostReadValid |-> hostReadData == expRead)
    else begin
        $display("mismatch hostReadData got %h expected %h",
                 $sampled(hostReadData), $sampled(expRead));
        errorCount++;
    end

    fillOnce: assert property (@(posedge clk) disable iff (rst)
        fillDone |-> outstanding == 1)
    else begin
        $display("fillDone without exactly one accepted fillStart");
        errorCount++;
    end

    fillPulse: assert property (@(posedge clk) disable iff (rst)
        fillDone |=> !fillDone && !fillBusy)
    else begin
        $display("fillDone longer than one cycle or fillBusy still high after it");
        errorCount++;
    end

    // first pixel of every frame carries the frame start
    frameStartPos: assert property (@(posedge clk) disable iff (rst)
        frameStart == (pixelValid && expIndex == 0))
    else begin
        $display("mismatch frameStart at index %h got %h expected %h",
                 $sampled(expIndex), $sampled(frameStart),
                 $sampled(pixelValid && expIndex == 0));
        errorCount++;
    end

    scanPixel: assert property (@(posedge clk) disable iff (rst)
        pixelValid |-> pixelOut == expPixel)
    else begin
        $display("mismatch pixelOut at index %h got %h expected %h",
                 $sampled(expIndex), $sampled(pixelOut), $sampled(expPixel));
        errorCount++;
    end

    frameLength: assert property (@(posedge clk) disable iff (rst)
        frameStart && seenFrame |-> frameCount == ScreenWords)
    else begin
        $display("mismatch pixelValid count per frame got %h expected %h",
                 $sampled(frameCount), ScreenWords);
        errorCount++;
    end

endmodule

`default_nettype wire

// File: bench/graphicsTb.sv
// testbench top: clock, reset, DUT, stimulus, reference model updates
// run limit and the per-test report
`default_nettype none

`include "gfx_consts.svh"

module graphicsTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ScreenW = `GFX_SCREEN_W;
    localparam int ScreenH = `GFX_SCREEN_H;
    localparam int ScreenWords = `GFX_SCREEN_W * `GFX_SCREEN_H;
    localparam int FbWords = `GFX_FB_WORDS;
    localparam int AddrSpan = 1 << `GFX_ADDR_W;
    // background fill, two frames, margin for host and rectangle traffic
    localparam int PlannedCycles = 3 * ScreenWords + 10000;
    localparam int CycleLimit = 2 * PlannedCycles;

    logic clk;
    logic rst;
    logic hostRead;
    logic hostWrite;
    gfxBusPkg::fbAddrT hostAddr;
    gfxBusPkg::pixelT hostWriteData;
    gfxBusPkg::pixelT hostReadData;
    logic hostReadValid;
    logic hostBusy;
    logic fillStart;
    logic [8:0] fillX;
    logic [7:0] fillY;
    logic [8:0] fillWidth;
    logic [7:0] fillHeight;
    gfxBusPkg::pixelT fillColor;
    logic fillBusy;
    logic fillDone;
    logic scanEnable;
    gfxBusPkg::pixelT pixelOut;
    logic pixelValid;
    logic frameStart;

    int seed;
    int cycleCount;
    int testCount;
    int lastChecks;
    int lastErrors;

    graphicsTop graphicsTop_i (
        .clk(clk), .rst(rst),
        .hostRead(hostRead), .hostWrite(hostWrite), .hostAddr(hostAddr),
        .hostWriteData(hostWriteData), .hostReadData(hostReadData),
        .hostReadValid(hostReadValid), .hostBusy(hostBusy),
        .fillStart(fillStart), .fillX(fillX), .fillY(fillY),
        .fillWidth(fillWidth), .fillHeight(fillHeight), .fillColor(fillColor),
        .fillBusy(fillBusy), .fillDone(fillDone),
        .scanEnable(scanEnable), .pixelOut(pixelOut),
        .pixelValid(pixelValid), .frameStart(frameStart)
    );

    graphicsChecks checks_i (
        .clk(clk), .rst(rst),
        .hostRead(hostRead), .hostWrite(hostWrite), .hostAddr(hostAddr),
        .hostBusy(hostBusy), .hostReadData(hostReadData), .hostReadValid(hostReadValid),
        .fillStart(fillStart), .fillBusy(fillBusy), .fillDone(fillDone),
        .scanEnable(scanEnable), .pixelOut(pixelOut),
        .pixelValid(pixelValid), .frameStart(frameStart)
    );

    always #10 clk = ~clk;

    // hard stop if some wait never ends
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("run stopped after %0d cycles, a wait never ended", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic reportTest(input string name);
        $display("test %0d %s: %0d checks, %0d errors", testCount + 1, name,
                 checks_i.checkCount - lastChecks, checks_i.errorCount - lastErrors);
        testCount++;
        lastChecks = checks_i.checkCount;
        lastErrors = checks_i.errorCount;
    endtask

    // one host access, called on a falling edge with hostBusy low
    task automatic hostAccess(input logic isWrite, input int addr,
                              input gfxBusPkg::pixelT data);
        hostRead = !isWrite;
        hostWrite = isWrite;
        hostAddr = gfxBusPkg::fbAddrT'(addr);
        hostWriteData = data;
        // words past the last bank are never stored
        if (isWrite && addr < FbWords) begin
            checks_i.refMem[addr] = data;
        end
        @(negedge clk);
        hostRead = 1'b0;
        hostWrite = 1'b0;
        while (hostBusy) @(negedge clk);
        if (!isWrite) begin
            while (!hostReadValid) @(negedge clk);
        end
    endtask

    task automatic readPixel(input int x, input int y);
        hostAccess(1'b0, y * ScreenW + x, '0);
    endtask

    task automatic fillLaunch(input int x, input int y, input int w, input int h,
                              input gfxBusPkg::pixelT color);
        fillStart = 1'b1;
        fillX = 9'(x);
        fillY = 8'(y);
        fillWidth = 9'(w);
        fillHeight = 8'(h);
        fillColor = color;
        // model row by row, pixel (x, y) at y * width + x
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                checks_i.refMem[(y + r) * ScreenW + x + c] = color;
            end
        end
        @(negedge clk);
        fillStart = 1'b0;
    endtask

    task automatic fillWait();
        while (!fillDone) @(negedge clk);
        // let the done pulse end before the next command
        @(negedge clk);
    endtask

    task automatic probeRect(input int x, input int y, input int w, input int h);
        // corners and a few inner points
        readPixel(x, y);
        readPixel(x + w - 1, y);
        readPixel(x, y + h - 1);
        readPixel(x + w - 1, y + h - 1);
        for (int i = 0; i < 4; i++) begin
            readPixel(x + randBelow(w), y + randBelow(h));
        end
        // one step outside each edge
        readPixel(x - 1, y);
        readPixel(x + w, y + h - 1);
        readPixel(x, y - 1);
        readPixel(x + w - 1, y + h);
    endtask

    initial begin
        int addrs [64];
        int x;
        int y;
        int w;
        int h;
        int addr;
        int frames;

        clk = 1'b0;
        rst = 1'b1;
        hostRead = 1'b0;
        hostWrite = 1'b0;
        hostAddr = '0;
        hostWriteData = '0;
        fillStart = 1'b0;
        fillX = '0;
        fillY = '0;
        fillWidth = '0;
        fillHeight = '0;
        fillColor = '0;
        scanEnable = 1'b0;
        seed = 32'h6254;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reportTest("reset state");

        // every fourth address past the last bank
        for (int i = 0; i < 64; i++) begin
            if (i % 4 == 3) begin
                addrs[i] = FbWords + randBelow(AddrSpan - FbWords);
            end else begin
                addrs[i] = randBelow(FbWords);
            end
            hostAccess(1'b1, addrs[i], gfxBusPkg::pixelT'(randBelow(65536)));
        end
        for (int i = 0; i < 64; i++) begin
            hostAccess(1'b0, addrs[i], '0);
        end
        reportTest("host write and read");

        // whole screen first so every scanned pixel has a model value
        fillLaunch(0, 0, ScreenW, ScreenH, gfxBusPkg::pixelT'(randBelow(65536)));
        fillWait();
        x = 20 + randBelow(200);
        y = 10 + randBelow(150);
        w = 1 + randBelow(60);
        h = 1 + randBelow(50);
        fillLaunch(x, y, w, h, gfxBusPkg::pixelT'(randBelow(65536)));
        fillWait();
        probeRect(x, y, w, h);
        reportTest("rectangle fill");

        // large enough to outlast the host traffic below
        x = 20 + randBelow(200);
        y = 10 + randBelow(150);
        w = 40 + randBelow(20);
        h = 20 + randBelow(10);
        fillLaunch(x, y, w, h, gfxBusPkg::pixelT'(randBelow(65536)));
        for (int i = 0; i < 12; i++) begin
            // off screen or out of range, never inside the rectangle
            if (i % 2 == 0) begin
                addr = ScreenWords + randBelow(FbWords - ScreenWords);
            end else begin
                addr = FbWords + randBelow(AddrSpan - FbWords);
            end
            hostAccess(1'b1, addr, gfxBusPkg::pixelT'(randBelow(65536)));
            hostAccess(1'b0, addr, '0);
        end
        fillWait();
        probeRect(x, y, w, h);
        reportTest("fill under host traffic");

        // third frame start closes two full frames
        scanEnable = 1'b1;
        frames = 0;
        while (frames < 3) begin
            @(negedge clk);
            if (frameStart) begin
                frames++;
            end
        end
        scanEnable = 1'b0;
        repeat (3) @(negedge clk);
        reportTest("scanout");

        fillLaunch(100, 50, 0, 7, 16'hffff);
        fillWait();
        fillLaunch(100, 50, 9, 0, 16'hffff);
        fillWait();
        readPixel(100, 50);
        readPixel(101, 50);
        readPixel(100, 51);
        reportTest("zero-size fill");

        $display("%0d tests, %0d checks, %0d errors", testCount,
                 checks_i.checkCount, checks_i.errorCount);
        if (checks_i.errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/fillEngine.sv
// rectangle fill, one pixel per granted cycle, x fastest
// stalls in place while the host holds the bus
`default_nettype none

`include "gfx_consts.svh"

module fillEngine (
    input  logic              clk,
    input  logic              rst,
    input  logic              fillStart,
    input  logic [8:0]        fillX,
    input  logic [7:0]        fillY,
    input  logic [8:0]        fillWidth,
    input  logic [7:0]        fillHeight,
    input  gfxBusPkg::pixelT  fillColor,
    output logic              fillBusy,
    output logic              fillDone,
    output logic              busReq,
    output gfxBusPkg::fbAddrT busAddr,
    output gfxBusPkg::pixelT  busData,
    input  gfxBusPkg::masterT grant
);

    localparam gfxBusPkg::fbAddrT RowStep = gfxBusPkg::fbAddrT'(`GFX_SCREEN_W);

    gfxCtrlPkg::fillStateT state;

    logic [8:0] colCount;
    logic [7:0] rowCount;
    logic [8:0] lastCol;
    logic [7:0] lastRow;
    gfxBusPkg::fbAddrT rowBase;
    gfxBusPkg::fbAddrT curAddr;
    gfxBusPkg::fbAddrT startBase;
    gfxBusPkg::pixelT colorQ;
    logic accept;
    logic step;
    logic rowEnd;
    logic emptyRect;

    // y * 320 as (y << 8) + (y << 6)
    assign startBase = (gfxBusPkg::fbAddrT'(fillY) << 8)
                     + (gfxBusPkg::fbAddrT'(fillY) << 6)
                     + gfxBusPkg::fbAddrT'(fillX);

    assign accept = fillStart && state != gfxCtrlPkg::FILL_RUN;
    assign emptyRect = fillWidth == 9'd0 || fillHeight == 8'd0;
    // one pixel written this cycle
    assign step = state == gfxCtrlPkg::FILL_RUN && grant == gfxBusPkg::MASTER_FILL;
    assign rowEnd = colCount == lastCol;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= gfxCtrlPkg::FILL_IDLE;
            colCount <= '0;
            rowCount <= '0;
        end else begin
            case (state)
                gfxCtrlPkg::FILL_IDLE, gfxCtrlPkg::FILL_DONE: begin
                    colCount <= '0;
                    rowCount <= '0;
                    if (accept) begin
                        // zero size skips straight to done
                        state <= emptyRect ? gfxCtrlPkg::FILL_DONE : gfxCtrlPkg::FILL_RUN;
                    end else begin
                        state <= gfxCtrlPkg::FILL_IDLE;
                    end
                end
                gfxCtrlPkg::FILL_RUN: begin
                    if (step) begin
                        if (!rowEnd) begin
                            colCount <= colCount + 9'd1;
                        end else if (rowCount == lastRow) begin
                            state <= gfxCtrlPkg::FILL_DONE;
                        end else begin
                            colCount <= '0;
                            rowCount <= rowCount + 8'd1;
                        end
                    end
                end
                default: state <= gfxCtrlPkg::FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rowBase <= startBase;
            curAddr <= startBase;
            colorQ <= fillColor;
            lastCol <= fillWidth - 9'd1;
            lastRow <= fillHeight - 8'd1;
        end else if (step) begin
            if (rowEnd) begin
                // next row starts one screen width further
                rowBase <= rowBase + RowStep;
                curAddr <= rowBase + RowStep;
            end else begin
                curAddr <= curAddr + 1'b1;
            end
        end
    end

    assign fillBusy = state == gfxCtrlPkg::FILL_RUN;
    assign fillDone = state == gfxCtrlPkg::FILL_DONE;
    assign busReq = fillBusy;
    // held while the grant is away
    assign busAddr = curAddr;
    assign busData = colorQ;

    // stalled engine keeps its pixel on the bus until the grant returns
    holdWhileStalled: assert property (@(posedge clk) disable iff (rst)
        busReq && grant != gfxBusPkg::MASTER_FILL
        |=> $stable(busAddr) && $stable(busData));

endmodule

`default_nettype wire

// File: rtl/framebuffer.sv
// dual-port banked pixel memory, port A read/write, port B read only
// each port decodes its own bank and masks addresses past the last bank
`default_nettype none

`include "gfx_consts.svh"

module framebuffer (
    input  logic              clk,
    input  gfxBusPkg::fbAddrT addressA,
    input  gfxBusPkg::pixelT  dataInA,
    input  logic              writeEnableA,
    output gfxBusPkg::pixelT  dataOutA,
    input  gfxBusPkg::fbAddrT addressB,
    output gfxBusPkg::pixelT  dataOutB
);

    localparam int OffsetW = $clog2(`GFX_BANK_WORDS);
    localparam int BankW = `GFX_ADDR_W - OffsetW;

    // bank select and range check, per port
    logic [BankW-1:0] bankA;
    logic [BankW-1:0] bankB;
    logic inRangeA;
    logic inRangeB;
    // registered copies, steer the read mux one cycle later
    logic [BankW-1:0] bankAQ;
    logic [BankW-1:0] bankBQ;
    logic inRangeAQ;
    logic inRangeBQ;

    gfxBusPkg::pixelT bankOutA [`GFX_BANKS];
    gfxBusPkg::pixelT bankOutB [`GFX_BANKS];

    assign bankA = addressA[`GFX_ADDR_W-1:OffsetW];
    assign bankB = addressB[`GFX_ADDR_W-1:OffsetW];
    assign inRangeA = addressA < gfxBusPkg::fbAddrT'(`GFX_FB_WORDS);
    assign inRangeB = addressB < gfxBusPkg::fbAddrT'(`GFX_FB_WORDS);

    for (genvar b = 0; b < `GFX_BANKS; b++) begin : genBank
        gfxBusPkg::pixelT mem [`GFX_BANK_WORDS];
        gfxBusPkg::pixelT readA;
        gfxBusPkg::pixelT readB;

        always_ff @(posedge clk) begin
            // out-of-range writes match no bank
            if (writeEnableA && inRangeA && bankA == BankW'(b)) begin
                mem[addressA[OffsetW-1:0]] <= dataInA;
            end
            // read old word, every bank every cycle
            readA <= mem[addressA[OffsetW-1:0]];
            readB <= mem[addressB[OffsetW-1:0]];
        end

        assign bankOutA[b] = readA;
        assign bankOutB[b] = readB;
    end

    always_ff @(posedge clk) begin
        bankAQ <= bankA;
        bankBQ <= bankB;
        inRangeAQ <= inRangeA;
        inRangeBQ <= inRangeB;
    end

    // zero outside the memory
    assign dataOutA = inRangeAQ ? bankOutA[bankAQ] : '0;
    assign dataOutB = inRangeBQ ? bankOutB[bankBQ] : '0;

    // range flag from the address compare must keep the mux inside the bank array
    aBankInRange: assert property (@(posedge clk)
        inRangeAQ |-> bankAQ < BankW'(`GFX_BANKS));
    bBankInRange: assert property (@(posedge clk)
        inRangeBQ |-> bankBQ < BankW'(`GFX_BANKS));

endmodule

`default_nettype wire

// File: rtl/gfxBusPkg.sv
// bus-level types for framebuffer port A and B
// pixel word, word address, arbiter grant
`default_nettype none

`include "gfx_consts.svh"

package gfxBusPkg;

    // one framebuffer word
    typedef logic [`GFX_PIXEL_W-1:0] pixelT;

    // word address, upper bits pick the bank
    typedef logic [`GFX_ADDR_W-1:0] fbAddrT;

    // owner of port A in the current cycle
    typedef enum logic [1:0] {
        MASTER_NONE,
        MASTER_HOST,
        MASTER_FILL
    } masterT;

endpackage

`default_nettype wire

// File: rtl/gfxCtrlPkg.sv
// control state types for the fill engine and the scanout
`default_nettype none

package gfxCtrlPkg;

    // fill engine FSM
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_RUN,
        FILL_DONE
    } fillStateT;

    // raster scan FSM
    typedef enum logic {
        SCAN_IDLE,
        SCAN_ACTIVE
    } scanStateT;

endpackage

`default_nettype wire

// File: rtl/gfx_consts.svh
// framebuffer and raster size constants
// pixel width, address width, bank geometry, screen size
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// bits per pixel word
`define GFX_PIXEL_W 16
// word address into the framebuffer
`define GFX_ADDR_W 17

// bank geometry, 96 banks of 1k words
`define GFX_BANK_WORDS 1024
`define GFX_BANKS 96
// first address past the last bank
`define GFX_FB_WORDS 98304

// raster size, pixel (x, y) at y * width + x
`define GFX_SCREEN_W 320
`define GFX_SCREEN_H 240

`endif

// File: rtl/graphicsTop.sv
// graphics subsystem top, framebuffer with host, fill and scanout
`default_nettype none

module graphicsTop (
    input  logic              clk,
    input  logic              rst,
    // host side
    input  logic              hostRead,
    input  logic              hostWrite,
    input  gfxBusPkg::fbAddrT hostAddr,
    input  gfxBusPkg::pixelT  hostWriteData,
    output gfxBusPkg::pixelT  hostReadData,
    output logic              hostReadValid,
    output logic              hostBusy,
    // fill side
    input  logic              fillStart,
    input  logic [8:0]        fillX,
    input  logic [7:0]        fillY,
    input  logic [8:0]        fillWidth,
    input  logic [7:0]        fillHeight,
    input  gfxBusPkg::pixelT  fillColor,
    output logic              fillBusy,
    output logic              fillDone,
    // scanout side
    input  logic              scanEnable,
    output gfxBusPkg::pixelT  pixelOut,
    output logic              pixelValid,
    output logic              frameStart
);

    // host master on port A
    logic hostReq;
    gfxBusPkg::fbAddrT hostBusAddr;
    gfxBusPkg::pixelT hostBusData;
    logic hostBusWrite;
    // fill master on port A
    logic fillReq;
    gfxBusPkg::fbAddrT fillBusAddr;
    gfxBusPkg::pixelT fillBusData;
    gfxBusPkg::masterT busGrant;
    // framebuffer ports
    gfxBusPkg::fbAddrT addressA;
    gfxBusPkg::pixelT dataInA;
    logic writeEnableA;
    gfxBusPkg::pixelT dataOutA;
    gfxBusPkg::fbAddrT addressB;
    gfxBusPkg::pixelT dataOutB;

    hostPort hostPort_i (
        .clk(clk), .rst(rst),
        .hostRead(hostRead), .hostWrite(hostWrite),
        .hostAddr(hostAddr), .hostWriteData(hostWriteData),
        .hostBusy(hostBusy), .hostReadData(hostReadData), .hostReadValid(hostReadValid),
        .busReq(hostReq), .busAddr(hostBusAddr), .busData(hostBusData),
        .busWrite(hostBusWrite), .grant(busGrant), .busReadData(dataOutA)
    );

    fillEngine fillEngine_i (
        .clk(clk), .rst(rst),
        .fillStart(fillStart), .fillX(fillX), .fillY(fillY),
        .fillWidth(fillWidth), .fillHeight(fillHeight), .fillColor(fillColor),
        .fillBusy(fillBusy), .fillDone(fillDone),
        .busReq(fillReq), .busAddr(fillBusAddr), .busData(fillBusData),
        .grant(busGrant)
    );

    portArbiter portArbiter_i (
        .clk(clk),
        .hostReq(hostReq), .hostAddr(hostBusAddr), .hostData(hostBusData),
        .hostWrite(hostBusWrite),
        .fillReq(fillReq), .fillAddr(fillBusAddr), .fillData(fillBusData),
        .grant(busGrant), .addressA(addressA), .dataInA(dataInA),
        .writeEnableA(writeEnableA)
    );

    framebuffer framebuffer_i (
        .clk(clk),
        .addressA(addressA), .dataInA(dataInA), .writeEnableA(writeEnableA),
        .dataOutA(dataOutA),
        .addressB(addressB), .dataOutB(dataOutB)
    );

    scanout scanout_i (
        .clk(clk), .rst(rst),
        .scanEnable(scanEnable), .addressB(addressB), .dataOutB(dataOutB),
        .pixelOut(pixelOut), .pixelValid(pixelValid), .frameStart(frameStart)
    );

endmodule

`default_nettype wire

// File: rtl/hostPort.sv
// host single-pixel access, one request at a time on the shared bus
`default_nettype none

module hostPort (
    input  logic               clk,
    input  logic               rst,
    input  logic               hostRead,
    input  logic               hostWrite,
    input  gfxBusPkg::fbAddrT  hostAddr,
    input  gfxBusPkg::pixelT   hostWriteData,
    output logic               hostBusy,
    output gfxBusPkg::pixelT   hostReadData,
    output logic               hostReadValid,
    output logic               busReq,
    output gfxBusPkg::fbAddrT  busAddr,
    output gfxBusPkg::pixelT   busData,
    output logic               busWrite,
    input  gfxBusPkg::masterT  grant,
    input  gfxBusPkg::pixelT   busReadData
);

    // latched request
    logic opWrite;
    gfxBusPkg::fbAddrT opAddr;
    gfxBusPkg::pixelT opData;
    // read granted last cycle, word arrives now
    logic readInFlight;
    logic accept;

    // strobes while busy are dropped
    assign accept = !hostBusy && (hostRead || hostWrite);

    always_ff @(posedge clk) begin
        if (rst) begin
            hostBusy <= 1'b0;
            readInFlight <= 1'b0;
            hostReadValid <= 1'b0;
        end else begin
            hostReadValid <= readInFlight;
            readInFlight <= 1'b0;
            if (accept) begin
                hostBusy <= 1'b1;
            end else if (hostBusy && grant == gfxBusPkg::MASTER_HOST) begin
                // access happens on this edge
                hostBusy <= 1'b0;
                readInFlight <= !opWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opWrite <= hostWrite;
            opAddr <= hostAddr;
            opData <= hostWriteData;
        end
        if (readInFlight) begin
            hostReadData <= busReadData;
        end
    end

    // request held until granted
    assign busReq = hostBusy;
    assign busAddr = opAddr;
    assign busData = opData;
    assign busWrite = opWrite;

    // the driver side owes us one strobe at a time
    oneStrobe: assert property (@(posedge clk) disable iff (rst)
        !(hostRead && hostWrite));

endmodule

`default_nettype wire

// File: rtl/portArbiter.sv
// fixed-priority owner select for framebuffer port A, host over fill
`default_nettype none

module portArbiter (
    input  logic              clk,
    input  logic              hostReq,
    input  gfxBusPkg::fbAddrT hostAddr,
    input  gfxBusPkg::pixelT  hostData,
    input  logic              hostWrite,
    input  logic              fillReq,
    input  gfxBusPkg::fbAddrT fillAddr,
    input  gfxBusPkg::pixelT  fillData,
    output gfxBusPkg::masterT grant,
    output gfxBusPkg::fbAddrT addressA,
    output gfxBusPkg::pixelT  dataInA,
    output logic              writeEnableA
);

    // last driven address, replayed while idle
    gfxBusPkg::fbAddrT heldAddr;

    always_comb begin
        if (hostReq) begin
            grant = gfxBusPkg::MASTER_HOST;
        end else if (fillReq) begin
            grant = gfxBusPkg::MASTER_FILL;
        end else begin
            grant = gfxBusPkg::MASTER_NONE;
        end
    end

    always_comb begin
        case (grant)
            gfxBusPkg::MASTER_HOST: begin
                addressA = hostAddr;
                dataInA = hostData;
                writeEnableA = hostWrite;
            end
            gfxBusPkg::MASTER_FILL: begin
                // fill only ever writes
                addressA = fillAddr;
                dataInA = fillData;
                writeEnableA = 1'b1;
            end
            default: begin
                addressA = heldAddr;
                dataInA = '0;
                writeEnableA = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        heldAddr <= addressA;
    end

    // no request means no write on port A
    idleQuiet: assert property (@(posedge clk)
        !hostReq && !fillReq |-> !writeEnableA);

endmodule

`default_nettype wire

// File: rtl/scanout.sv
// raster address generator on port B, 320x240 pixel stream
`default_nettype none

`include "gfx_consts.svh"

module scanout (
    input  logic              clk,
    input  logic              rst,
    input  logic              scanEnable,
    output gfxBusPkg::fbAddrT addressB,
    input  gfxBusPkg::pixelT  dataOutB,
    output gfxBusPkg::pixelT  pixelOut,
    output logic              pixelValid,
    output logic              frameStart
);

    localparam gfxBusPkg::fbAddrT LastAddr =
        gfxBusPkg::fbAddrT'(`GFX_SCREEN_W * `GFX_SCREEN_H - 1);

    gfxCtrlPkg::scanStateT state;
    gfxBusPkg::fbAddrT scanAddr;
    // address on port B is read this cycle
    logic reading;

    assign reading = state == gfxCtrlPkg::SCAN_ACTIVE && scanEnable;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= gfxCtrlPkg::SCAN_IDLE;
            scanAddr <= '0;
            pixelValid <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            // flags trail the address by the memory read cycle
            pixelValid <= reading;
            frameStart <= reading && scanAddr == '0;
            case (state)
                gfxCtrlPkg::SCAN_IDLE: begin
                    scanAddr <= '0;
                    if (scanEnable) begin
                        state <= gfxCtrlPkg::SCAN_ACTIVE;
                    end
                end
                gfxCtrlPkg::SCAN_ACTIVE: begin
                    if (!scanEnable) begin
                        // restart from the top next time
                        state <= gfxCtrlPkg::SCAN_IDLE;
                        scanAddr <= '0;
                    end else if (scanAddr == LastAddr) begin
                        scanAddr <= '0;
                    end else begin
                        scanAddr <= scanAddr + 1'b1;
                    end
                end
                default: state <= gfxCtrlPkg::SCAN_IDLE;
            endcase
        end
    end

    assign addressB = scanAddr;
    // bank read register already holds the pixel
    assign pixelOut = dataOutB;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the graphics testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module graphicsTb -f tb.f \
    --Mdir obj_dir -o graphicsSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/graphicsSim > log.txt 2>&1
runStatus=$?
cat log.txt
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Test FAILED" log.txt; then
    exit 1
fi
exit 0

// File: tb.f
+incdir+rtl
rtl/gfxBusPkg.sv
rtl/gfxCtrlPkg.sv
rtl/framebuffer.sv
rtl/hostPort.sv
rtl/fillEngine.sv
rtl/portArbiter.sv
rtl/scanout.sv
rtl/graphicsTop.sv
bench/graphicsChecks.sv
bench/graphicsTb.sv
